/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = async_fifo_tb
FILELIST  = async_fifo.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* async_fifo.f */
+incdir+source
source/fifo_pkg.sv
source/dualport_ram_async.sv
source/cdc_sync.sv
source/wr_ptr_full.sv
source/rd_ptr_empty.sv
source/async_fifo.sv
verif/async_fifo_sva.sv
verif/async_fifo_tb.sv

/* source/async_fifo.sv */
`timescale 1ns/100ps

module async_fifo (
  input  logic            wr_clk,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            full,
  output logic            empty,
  output logic            afull,
  output logic            aempty
);

  logic            wr_rst_sync_n;
  logic            rd_rst_sync_n;
  logic            wr_en_ram;
  logic            rd_en_ram;
  fifo_pkg::addr_t wr_addr;
  fifo_pkg::addr_t rd_addr;
  fifo_pkg::ptr_t  wr_ptr_gray;
  fifo_pkg::ptr_t  rd_ptr_gray;
  fifo_pkg::ptr_t  wr_ptr_gray_sync;   // in rd_clk domain
  fifo_pkg::ptr_t  rd_ptr_gray_sync;   // in wr_clk domain

  wr_ptr_full u_wr_ptr_full (
    .wr_clk           (wr_clk),
    .rd_rst_n         (rd_rst_n),
    .wr_en            (wr_en),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .wr_rst_sync_n    (wr_rst_sync_n),
    .wr_en_ram        (wr_en_ram),
    .wr_addr          (wr_addr),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  rd_ptr_empty u_rd_ptr_empty (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .rd_rst_sync_n    (rd_rst_sync_n),
    .rd_en_ram        (rd_en_ram),
    .rd_addr          (rd_addr),
    .rd_ptr_gray      (rd_ptr_gray),
    .empty            (empty),
    .aempty           (aempty)
  );

  cdc_sync wr2rd (
    .clk          (rd_clk),
    .rst_sync_n   (rd_rst_sync_n),
    .ptr_gray_in  (wr_ptr_gray),
    .ptr_gray_out (wr_ptr_gray_sync)
  );

  cdc_sync rd2wr (
    .clk          (wr_clk),
    .rst_sync_n   (wr_rst_sync_n),
    .ptr_gray_in  (rd_ptr_gray),
    .ptr_gray_out (rd_ptr_gray_sync)
  );

  dualport_ram_async u_ram (
    .wr_clk        (wr_clk),
    .wr_en_ram     (wr_en_ram),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_clk        (rd_clk),
    .rd_rst_sync_n (rd_rst_sync_n),
    .rd_en_ram     (rd_en_ram),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

endmodule

/* source/cdc_sync.sv */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module cdc_sync (
  input  logic           clk,
  input  logic           rst_sync_n,
  input  fifo_pkg::ptr_t ptr_gray_in,
  output fifo_pkg::ptr_t ptr_gray_out
);

  // gray coding keeps at most one bit in flight per source edge,
  // so the captured value is either the old or the new pointer
  fifo_pkg::ptr_t sync_q [`FIFO_SYNC_STAGES];

  always_ff @(posedge clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= ptr_gray_in;      // first stage, may go metastable
      for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign ptr_gray_out = sync_q[`FIFO_SYNC_STAGES-1];

endmodule

/* source/dualport_ram_async.sv */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module dualport_ram_async (
  input  logic            wr_clk,
  input  logic            wr_en_ram,
  input  fifo_pkg::addr_t wr_addr,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_sync_n,
  input  logic            rd_en_ram,
  input  fifo_pkg::addr_t rd_addr,
  output fifo_pkg::data_t rd_data
);

  fifo_pkg::data_t mem [`FIFO_DEPTH];

  // write port, enable already qualified by full
  always_ff @(posedge wr_clk) begin
    if (wr_en_ram) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, holds between pops
  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_data <= '0;
    end else if (rd_en_ram) begin
      rd_data <= mem[rd_addr];       // qualified by empty
    end
  end

endmodule

/* source/fifo_defs.svh */
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// word and storage geometry
`define FIFO_DATA_WIDTH   8
`define FIFO_DEPTH        16
`define FIFO_ADDR_WIDTH   4     // log2 of depth

// used count at or above which afull is set
`define FIFO_AFULL_LEVEL  14

// used count at or below which aempty is set
`define FIFO_AEMPTY_LEVEL 2

// flops per pointer synchronizer, also per reset synchronizer
`define FIFO_SYNC_STAGES  2

`endif

/* source/fifo_pkg.sv */
`include "fifo_defs.svh"

package fifo_pkg;

  // one stored word
  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

  // ram address, no wrap bit
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

  // pointer with wrap bit, binary or gray
  typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

  // used count, 0 up to depth
  typedef logic [`FIFO_ADDR_WIDTH:0] level_t;

endpackage

/* source/rd_ptr_empty.sv */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module rd_ptr_empty (
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  input  fifo_pkg::ptr_t  wr_ptr_gray_sync,
  output logic            rd_rst_sync_n,
  output logic            rd_en_ram,
  output fifo_pkg::addr_t rd_addr,
  output fifo_pkg::ptr_t  rd_ptr_gray,
  output logic            empty,
  output logic            aempty
);

  logic [`FIFO_SYNC_STAGES-1:0] rst_pipe;

  fifo_pkg::ptr_t   rd_bin;
  fifo_pkg::ptr_t   rd_bin_nxt;
  fifo_pkg::ptr_t   rd_gray_nxt;
  fifo_pkg::ptr_t   wr_bin_sync;
  fifo_pkg::level_t used_nxt;

  // async assert, deassert on rd_clk
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[`FIFO_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rd_rst_sync_n = rst_pipe[`FIFO_SYNC_STAGES-1];

  assign rd_en_ram   = rd_en & ~empty;           // accepted pop
  assign rd_addr     = rd_bin[`FIFO_ADDR_WIDTH-1:0];
  assign rd_bin_nxt  = rd_bin + fifo_pkg::ptr_t'(rd_en_ram);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  // synchronized write pointer back to binary
  always_comb begin
    for (int i = 0; i <= `FIFO_ADDR_WIDTH; i++) begin
      wr_bin_sync[i] = ^(wr_ptr_gray_sync >> i);
    end
  end

  // may lag the true count, so aempty errs high
  assign used_nxt = fifo_pkg::level_t'(wr_bin_sync - rd_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_bin      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // empty set at the edge of the last pop
  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_gray_nxt == wr_ptr_gray_sync);
      aempty <= (used_nxt <= fifo_pkg::level_t'(`FIFO_AEMPTY_LEVEL));
    end
  end

endmodule

/* source/wr_ptr_full.sv */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module wr_ptr_full (
  input  logic            wr_clk,
  input  logic            rd_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::ptr_t  rd_ptr_gray_sync,
  output logic            wr_rst_sync_n,
  output logic            wr_en_ram,
  output fifo_pkg::addr_t wr_addr,
  output fifo_pkg::ptr_t  wr_ptr_gray,
  output logic            full,
  output logic            afull
);

  logic [`FIFO_SYNC_STAGES-1:0] rst_pipe;

  fifo_pkg::ptr_t   wr_bin;
  fifo_pkg::ptr_t   wr_bin_nxt;
  fifo_pkg::ptr_t   wr_gray_nxt;
  fifo_pkg::ptr_t   rd_bin_sync;
  fifo_pkg::ptr_t   rd_gray_full;
  fifo_pkg::level_t used_nxt;

  // async assert, deassert on wr_clk
  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[`FIFO_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign wr_rst_sync_n = rst_pipe[`FIFO_SYNC_STAGES-1];

  assign wr_en_ram   = wr_en & ~full;            // accepted write
  assign wr_addr     = wr_bin[`FIFO_ADDR_WIDTH-1:0];
  assign wr_bin_nxt  = wr_bin + fifo_pkg::ptr_t'(wr_en_ram);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // gray to binary for the far pointer
  always_comb begin
    for (int i = 0; i <= `FIFO_ADDR_WIDTH; i++) begin
      rd_bin_sync[i] = ^(rd_ptr_gray_sync >> i);
    end
  end

  // read pointer one full lap behind, two top bits flipped in gray
  assign rd_gray_full = {~rd_ptr_gray_sync[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                         rd_ptr_gray_sync[`FIFO_ADDR_WIDTH-2:0]};

  assign used_nxt = fifo_pkg::level_t'(wr_bin_nxt - rd_bin_sync);

  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      wr_bin      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_ptr_gray <= wr_gray_nxt;
    end
  end

  // flags from the next pointer, never set late
  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_gray_nxt == rd_gray_full);
      afull <= (used_nxt >= fifo_pkg::level_t'(`FIFO_AFULL_LEVEL));
    end
  end

endmodule

/* verif/async_fifo_sva.sv */
`timescale 1ns/100ps

module async_fifo_sva (
  input logic           clk,
  input logic           rst_n,
  input fifo_pkg::ptr_t ptr_gray,
  input logic           flag,
  input logic           aflag,
  input logic           flag_rst_val
);

  int unsigned fail_count = 0;

  gray_one_step: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(ptr_gray ^ $past(ptr_gray)))
  else begin
    fail_count++;
    $error("gray pointer changed by more than one bit in one clock");
  end

  // first flags computed after release still match the idle values
  reset_values: assert property (@(posedge clk)
    $rose(rst_n) |=> (flag == flag_rst_val && aflag == flag_rst_val))
  else begin
    fail_count++;
    $error("flags left their reset values right after reset");
  end

  // full implies afull, empty implies aempty
  flag_order: assert property (@(posedge clk) disable iff (!rst_n) flag |-> aflag)
  else begin
    fail_count++;
    $error("flag set without its almost flag");
  end

endmodule

bind wr_ptr_full async_fifo_sva wr_sva (
  .clk          (wr_clk),
  .rst_n        (wr_rst_sync_n),
  .ptr_gray     (wr_ptr_gray),
  .flag         (full),
  .aflag        (afull),
  .flag_rst_val (1'b0)
);

bind rd_ptr_empty async_fifo_sva rd_sva (
  .clk          (rd_clk),
  .rst_n        (rd_rst_sync_n),
  .ptr_gray     (rd_ptr_gray),
  .flag         (empty),
  .aflag        (aempty),
  .flag_rst_val (1'b1)
);

/* verif/async_fifo_tb.sv */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module async_fifo_tb;

  localparam int          WR_HALF     = 50;
  localparam int          RD_HALF     = 35;    // 70 ns read clock
  localparam logic [31:0] SEED        = 32'd75010;
  localparam int          MODE_IDLE   = 0;
  localparam int          MODE_RAND   = 1;
  localparam int          MODE_ALWAYS = 2;
  localparam int          MODE_BURST  = 3;

  logic            wr_clk;
  logic            rd_clk;
  logic            rd_rst_n;
  logic            wr_en;
  logic            rd_en;
  fifo_pkg::data_t wr_data;
  fifo_pkg::data_t rd_data;
  logic            full;
  logic            empty;
  logic            afull;
  logic            aempty;

  fifo_pkg::data_t ref_q[$];           // accepted words, oldest first
  fifo_pkg::data_t last_popped;
  logic [31:0]     wr_state;
  logic [31:0]     rd_state;
  logic [3:0]      wr_thresh;
  logic [3:0]      rd_thresh;
  logic            pop_pending;        // pop accepted at the coming rd_clk edge
  int              wr_mode;
  int              rd_mode;
  int              wr_target;
  int              rd_target;
  int              wr_push_count;
  int              rd_pop_count;
  int              check_count = 0;
  int              error_count = 0;

  async_fifo uut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #WR_HALF wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #RD_HALF rd_clk = ~rd_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // oldest word not yet read
  function automatic fifo_pkg::data_t expected_word();
    return ref_q.pop_front();
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen in time", what);
    error_count++;
  endtask

  task automatic wr_cycles(input int n);
    repeat (n) @(negedge wr_clk);
  endtask

  initial begin : write_driver
    wr_en = 1'b0;
    wr_data = '0;
    wr_state = SEED;
    wr_push_count = 0;
    forever begin
      @(negedge wr_clk);
      wr_state = xorshift32(wr_state);
      case (wr_mode)
        MODE_RAND:   wr_en = (wr_state[3:0] < wr_thresh);
        MODE_ALWAYS: wr_en = 1'b1;
        MODE_BURST:  wr_en = (wr_push_count < wr_target);
        default:     wr_en = 1'b0;
      endcase
      wr_data = fifo_pkg::data_t'(wr_state >> 8);
      if (wr_en && !full) begin          // accepted at the next rising edge
        ref_q.push_back(wr_data);
        wr_push_count++;
      end
    end
  end

  initial begin : read_driver
    rd_en = 1'b0;
    pop_pending = 1'b0;
    rd_state = xorshift32(SEED ^ 32'h0000a5a5);
    rd_pop_count = 0;
    forever begin
      @(negedge rd_clk);
      rd_state = xorshift32(rd_state);
      case (rd_mode)
        MODE_RAND:   rd_en = (rd_state[7:4] < rd_thresh);
        MODE_ALWAYS: rd_en = 1'b1;
        MODE_BURST:  rd_en = (rd_pop_count < rd_target);
        default:     rd_en = 1'b0;
      endcase
      pop_pending = rd_en && !empty;
      if (pop_pending) begin
        rd_pop_count++;
      end
    end
  end

  initial begin : compare_data
    fifo_pkg::data_t exp_word;
    forever begin
      @(posedge rd_clk);
      if (pop_pending) begin
        @(negedge rd_clk);               // rd_data settled after the pop edge
        if (ref_q.size() == 0) begin
          $display("Read side popped a word that was never written");
          error_count++;
        end else begin
          exp_word = expected_word();
          last_popped = exp_word;
          check_value(32'(rd_data), 32'(exp_word), "read data");
        end
      end
    end
  end

  task automatic drain_all();
    int i;
    rd_mode = MODE_ALWAYS;
    i = 0;
    while (rd_pop_count != wr_push_count && i < 400) begin
      @(posedge rd_clk);
      i++;
    end
    if (rd_pop_count != wr_push_count) begin
      report_timeout("draining all written words");
    end
    wr_cycles(12);
    rd_mode = MODE_IDLE;
    check_value(32'(aempty), 32'd1, "aempty after drain");
    check_value(32'(empty), 32'd1, "empty after drain");
  endtask

  task automatic fill_until_full();
    int start;
    int i;
    start = wr_push_count;
    wr_mode = MODE_ALWAYS;
    i = 0;
    while (!full && i < 100) begin
      @(negedge wr_clk);
      i++;
    end
    if (!full) begin
      report_timeout("full rising during fill");
    end else begin
      check_value(32'(wr_push_count - start), `FIFO_DEPTH, "words accepted before full");
    end
    repeat (8) begin                     // writes while full are dropped
      @(negedge wr_clk);
      check_value(32'(full), 32'd1, "full held while writing");
      check_value(32'(afull), 32'd1, "afull while full");
    end
    wr_mode = MODE_IDLE;
    wr_cycles(12);
  endtask

  task automatic drain_until_empty();
    int start;
    int i;
    start = rd_pop_count;
    rd_mode = MODE_ALWAYS;
    i = 0;
    while (!empty && i < 100) begin
      @(negedge rd_clk);
      i++;
    end
    if (!empty) begin
      report_timeout("empty rising during drain");
    end else begin
      check_value(32'(rd_pop_count - start), `FIFO_DEPTH, "words read before empty");
    end
    repeat (6) begin                     // reads while empty
      @(negedge rd_clk);
      check_value(32'(rd_data), 32'(last_popped), "rd_data held while empty");
      check_value(32'(aempty), 32'd1, "aempty while empty");
    end
    rd_mode = MODE_IDLE;
    wr_cycles(12);
  endtask

  task automatic move_to_level(input int target);
    int diff;
    int i;
    diff = target - ref_q.size();
    i = 0;
    if (diff > 0) begin
      wr_target = wr_push_count + diff;
      wr_mode = MODE_BURST;
      while (wr_push_count < wr_target && i < 200) begin
        @(posedge wr_clk);
        i++;
      end
      if (wr_push_count < wr_target) begin
        report_timeout("burst of writes");
      end
    end else if (diff < 0) begin
      rd_target = rd_pop_count - diff;
      rd_mode = MODE_BURST;
      while (rd_pop_count < rd_target && i < 300) begin
        @(posedge rd_clk);
        i++;
      end
      if (rd_pop_count < rd_target) begin
        report_timeout("burst of reads");
      end
    end
    wr_cycles(12);                       // pointers cross, flags release
    wr_mode = MODE_IDLE;
    rd_mode = MODE_IDLE;
    @(negedge wr_clk);
    check_value(32'(afull), 32'(ref_q.size() >= `FIFO_AFULL_LEVEL),
                $sformatf("afull at level %0d", ref_q.size()));
    check_value(32'(full), 32'(ref_q.size() == `FIFO_DEPTH),
                $sformatf("full at level %0d", ref_q.size()));
    @(negedge rd_clk);
    check_value(32'(aempty), 32'(ref_q.size() <= `FIFO_AEMPTY_LEVEL),
                $sformatf("aempty at level %0d", ref_q.size()));
    check_value(32'(empty), 32'(ref_q.size() == 0),
                $sformatf("empty at level %0d", ref_q.size()));
  endtask

  initial begin : main_seq
    int levels [15] = '{1, 2, 3, 8, 13, 14, 15, 16, 15, 14, 13, 3, 2, 1, 0};
    int sva_fails;
    rd_rst_n = 1'b0;
    wr_mode = MODE_IDLE;
    rd_mode = MODE_IDLE;
    wr_thresh = 4'd8;
    rd_thresh = 4'd8;
    wr_target = 0;
    rd_target = 0;
    repeat (10) @(posedge wr_clk);
    @(negedge wr_clk);
    rd_rst_n = 1'b1;
    wr_cycles(6);

    @(negedge rd_clk);
    check_value(32'(empty), 32'd1, "empty after reset");
    check_value(32'(aempty), 32'd1, "aempty after reset");
    @(negedge wr_clk);
    check_value(32'(full), 32'd0, "full after reset");
    check_value(32'(afull), 32'd0, "afull after reset");

    // writer faster first, then reader faster
    wr_thresh = 4'd12;
    rd_thresh = 4'd6;
    wr_mode = MODE_RAND;
    rd_mode = MODE_RAND;
    wr_cycles(300);
    wr_thresh = 4'd5;
    rd_thresh = 4'd12;
    wr_cycles(300);
    wr_mode = MODE_IDLE;
    drain_all();

    fill_until_full();
    drain_until_empty();

    foreach (levels[i]) begin
      move_to_level(levels[i]);
    end

    sva_fails = uut.u_wr_ptr_full.wr_sva.fail_count + uut.u_rd_ptr_empty.rd_sva.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, sva_fails);
    if (error_count == 0 && sva_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
